//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "All tests passed" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/branch_unit.sv
module branch_unit (
  input  id_pkg::alu_op_e alu_op_i,
  input  id_pkg::word_t   pc_i,
  input  id_pkg::word_t   src1_i,
  input  id_pkg::word_t   src2_i,
  input  id_pkg::word_t   offset_i,
  output logic            taken_o,
  output id_pkg::word_t   target_o,
  output id_pkg::word_t   link_o
);

  import id_pkg::*;

  logic equal;
  logic less_s;
  logic less_u;

  assign equal  = (src1_i == src2_i);
  assign less_s = ($signed(src1_i) < $signed(src2_i));
  assign less_u = (src1_i < src2_i);

  always_comb
  begin
    case (alu_op_i)
      OP_B, OP_BL, OP_JIRL: taken_o = 1'b1;
      OP_BEQ:               taken_o = equal;
      OP_BNE:               taken_o = ~equal;
      OP_BLT:               taken_o = less_s;
      OP_BGE:               taken_o = ~less_s;
      OP_BLTU:              taken_o = less_u;
      OP_BGEU:              taken_o = ~less_u;
      default:              taken_o = 1'b0;
    endcase
  end

  // jirl is register relative, all others pc relative
  assign target_o = (alu_op_i == OP_JIRL) ? src1_i + offset_i : pc_i + offset_i;
  assign link_o   = pc_i + INST_STEP;

endmodule

//--- hdl/id_ex_register.sv
module id_ex_register (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               issue_i,
  input  logic               hazard1_i,
  input  logic               hazard2_i,
  input  id_pkg::word_t      pc_i,
  input  id_pkg::alu_op_e    alu_op_i,
  input  id_pkg::alu_sel_e   alu_sel_i,
  input  id_pkg::word_t      src1_i,
  input  id_pkg::word_t      src2_i,
  input  id_pkg::word_t      imm_i,
  input  logic               wreg_i,
  input  id_pkg::reg_addr_t  waddr_i,
  input  id_pkg::word_t      link_i,
  input  logic               taken_i,
  input  id_pkg::word_t      target_i,
  input  id_pkg::excp_code_t excp_code_i,
  output logic               stall_o,
  output logic               ex_valid_o,
  output id_pkg::word_t      ex_pc_o,
  output id_pkg::alu_op_e    ex_alu_op_o,
  output id_pkg::alu_sel_e   ex_alu_sel_o,
  output id_pkg::word_t      ex_src1_o,
  output id_pkg::word_t      ex_src2_o,
  output id_pkg::word_t      ex_offset_o,
  output logic               ex_wreg_o,
  output id_pkg::reg_addr_t  ex_waddr_o,
  output id_pkg::word_t      ex_link_o,
  output logic               br_taken_o,
  output id_pkg::word_t      br_target_o,
  output logic               excp_o,
  output id_pkg::excp_code_t excp_code_o
);

  import id_pkg::*;

  logic capture;

  assign stall_o = issue_i & (hazard1_i | hazard2_i);
  assign capture = issue_i & ~stall_o;

  // Anything not captured becomes a bubble
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ex_valid_o   <= 1'b0;
      ex_alu_op_o  <= OP_NOP;
      ex_alu_sel_o <= SEL_NOP;
      ex_wreg_o    <= 1'b0;
      br_taken_o   <= 1'b0;
      excp_o       <= 1'b0;
      excp_code_o  <= '0;
    end
    else
    begin
      ex_valid_o   <= capture;
      ex_alu_op_o  <= capture ? alu_op_i : OP_NOP;
      ex_alu_sel_o <= capture ? alu_sel_i : SEL_NOP;
      ex_wreg_o    <= capture & wreg_i;
      br_taken_o   <= capture & taken_i;
      excp_o       <= capture & (|excp_code_i);
      excp_code_o  <= capture ? excp_code_i : '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      ex_pc_o     <= pc_i;
      ex_src1_o   <= src1_i;
      ex_src2_o   <= src2_i;
      ex_offset_o <= imm_i;
      ex_waddr_o  <= waddr_i;
      ex_link_o   <= link_i;
      br_target_o <= target_i;
    end
  end

endmodule

//--- hdl/id_pkg.sv
package id_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic [5:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_SLT,
    OP_SLTU,
    OP_AND,
    OP_OR,
    OP_NOR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_LUI,
    OP_PCADD,
    OP_LD_B,
    OP_LD_H,
    OP_LD_W,
    OP_LD_BU,
    OP_LD_HU,
    OP_ST_B,
    OP_ST_H,
    OP_ST_W,
    OP_B,
    OP_BL,
    OP_JIRL,
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_BLTU,
    OP_BGEU,
    OP_SYSCALL,
    OP_BREAK
  } alu_op_e;

  typedef enum logic [2:0] {
    SEL_NOP,
    SEL_LOGIC,
    SEL_SHIFT,
    SEL_ARITH,
    SEL_MOVE,
    SEL_JUMP,
    SEL_LOAD_STORE
  } alu_sel_e;

  // Bit 0 is ine
  typedef struct packed {
    logic sys;
    logic brk;
    logic ine;
  } excp_code_t;

  localparam reg_addr_t LINK_REG  = 5'd1;
  localparam word_t     INST_STEP = 32'd4;

endpackage

//--- hdl/id_stage_top.sv
module id_stage_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               if_valid_i,
  input  id_pkg::word_t      pc_i,
  input  id_pkg::word_t      inst_i,
  output logic               rf_re1_o,
  output id_pkg::reg_addr_t  rf_addr1_o,
  output logic               rf_re2_o,
  output id_pkg::reg_addr_t  rf_addr2_o,
  input  id_pkg::word_t      rf_data1_i,
  input  id_pkg::word_t      rf_data2_i,
  input  logic               ex_wreg_i,
  input  id_pkg::reg_addr_t  ex_waddr_i,
  input  id_pkg::word_t      ex_wdata_i,
  input  id_pkg::alu_op_e    ex_alu_op_i,
  input  logic               mem_wreg_i,
  input  id_pkg::reg_addr_t  mem_waddr_i,
  input  id_pkg::word_t      mem_wdata_i,
  output logic               stall_o,
  output logic               ex_valid_o,
  output id_pkg::word_t      ex_pc_o,
  output id_pkg::alu_op_e    ex_alu_op_o,
  output id_pkg::alu_sel_e   ex_alu_sel_o,
  output id_pkg::word_t      ex_src1_o,
  output id_pkg::word_t      ex_src2_o,
  output id_pkg::word_t      ex_offset_o,
  output logic               ex_wreg_o,
  output id_pkg::reg_addr_t  ex_waddr_o,
  output id_pkg::word_t      ex_link_o,
  output logic               br_taken_o,
  output id_pkg::word_t      br_target_o,
  output logic               excp_o,
  output id_pkg::excp_code_t excp_code_o
);

  import id_pkg::*;

  alu_op_e    alu_op;
  alu_sel_e   alu_sel;
  logic       wreg;
  reg_addr_t  waddr;
  word_t      imm;
  logic       use_imm;
  excp_code_t excp_code;
  word_t      src1;
  word_t      src2;
  logic       hazard1;
  logic       hazard2;
  logic       taken;
  word_t      target;
  word_t      link;

  inst_decoder u_inst_decoder (
    .inst_i      (inst_i),
    .alu_op_o    (alu_op),
    .alu_sel_o   (alu_sel),
    .re1_o       (rf_re1_o),
    .re2_o       (rf_re2_o),
    .raddr1_o    (rf_addr1_o),
    .raddr2_o    (rf_addr2_o),
    .wreg_o      (wreg),
    .waddr_o     (waddr),
    .imm_o       (imm),
    .use_imm_o   (use_imm),
    .excp_code_o (excp_code)
  );

  operand_forward u_src1 (
    .re_i          (rf_re1_o),
    .raddr_i       (rf_addr1_o),
    .rf_data_i     (rf_data1_i),
    .ex_wreg_i     (ex_wreg_i),
    .ex_waddr_i    (ex_waddr_i),
    .ex_wdata_i    (ex_wdata_i),
    .ex_alu_op_i   (ex_alu_op_i),
    .mem_wreg_i    (mem_wreg_i),
    .mem_waddr_i   (mem_waddr_i),
    .mem_wdata_i   (mem_wdata_i),
    .use_imm_i     (use_imm),
    .imm_i         (imm),
    .operand_o     (src1),
    .load_hazard_o (hazard1)
  );

  operand_forward u_src2 (
    .re_i          (rf_re2_o),
    .raddr_i       (rf_addr2_o),
    .rf_data_i     (rf_data2_i),
    .ex_wreg_i     (ex_wreg_i),
    .ex_waddr_i    (ex_waddr_i),
    .ex_wdata_i    (ex_wdata_i),
    .ex_alu_op_i   (ex_alu_op_i),
    .mem_wreg_i    (mem_wreg_i),
    .mem_waddr_i   (mem_waddr_i),
    .mem_wdata_i   (mem_wdata_i),
    .use_imm_i     (use_imm),
    .imm_i         (imm),
    .operand_o     (src2),
    .load_hazard_o (hazard2)
  );

  branch_unit u_branch_unit (
    .alu_op_i (alu_op),
    .pc_i     (pc_i),
    .src1_i   (src1),
    .src2_i   (src2),
    .offset_i (imm),
    .taken_o  (taken),
    .target_o (target),
    .link_o   (link)
  );

  id_ex_register u_id_ex_register (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .issue_i      (if_valid_i),
    .hazard1_i    (hazard1),
    .hazard2_i    (hazard2),
    .pc_i         (pc_i),
    .alu_op_i     (alu_op),
    .alu_sel_i    (alu_sel),
    .src1_i       (src1),
    .src2_i       (src2),
    .imm_i        (imm),
    .wreg_i       (wreg),
    .waddr_i      (waddr),
    .link_i       (link),
    .taken_i      (taken),
    .target_i     (target),
    .excp_code_i  (excp_code),
    .stall_o      (stall_o),
    .ex_valid_o   (ex_valid_o),
    .ex_pc_o      (ex_pc_o),
    .ex_alu_op_o  (ex_alu_op_o),
    .ex_alu_sel_o (ex_alu_sel_o),
    .ex_src1_o    (ex_src1_o),
    .ex_src2_o    (ex_src2_o),
    .ex_offset_o  (ex_offset_o),
    .ex_wreg_o    (ex_wreg_o),
    .ex_waddr_o   (ex_waddr_o),
    .ex_link_o    (ex_link_o),
    .br_taken_o   (br_taken_o),
    .br_target_o  (br_target_o),
    .excp_o       (excp_o),
    .excp_code_o  (excp_code_o)
  );

endmodule

//--- hdl/inst_decoder.sv
module inst_decoder (
  input  id_pkg::word_t      inst_i,
  output id_pkg::alu_op_e    alu_op_o,
  output id_pkg::alu_sel_e   alu_sel_o,
  output logic               re1_o,
  output logic               re2_o,
  output id_pkg::reg_addr_t  raddr1_o,
  output id_pkg::reg_addr_t  raddr2_o,
  output logic               wreg_o,
  output id_pkg::reg_addr_t  waddr_o,
  output id_pkg::word_t      imm_o,
  output logic               use_imm_o,
  output id_pkg::excp_code_t excp_code_o
);

  import id_pkg::*;
  import loong_isa_pkg::*;

  logic [16:0]       prefix;
  reg_addr_t         rd;
  reg_addr_t         rj;
  reg_addr_t         rk;
  logic              reg_form;
  logic [SI12_W-1:0] si12;
  logic [UI5_W-1:0]  ui5;
  logic [SI16_W-1:0] si16;
  logic [SI20_W-1:0] si20;
  logic [SI26_W-1:0] si26;
  word_t             sext12;
  word_t             zext12;
  word_t             offs16;
  word_t             offs26;

  assign prefix = inst_i[31:15];
  assign rd     = inst_i[RD_LSB +: REG_W];
  assign rj     = inst_i[RJ_LSB +: REG_W];
  assign rk     = inst_i[RK_LSB +: REG_W];

  // 3R group shares its upper 12 bits
  assign reg_form = (inst_i[31:20] == OPC17_ADD_W[16:5]);

  assign si12 = inst_i[IMM_LSB +: SI12_W];
  assign ui5  = inst_i[IMM_LSB +: UI5_W];
  assign si16 = inst_i[IMM_LSB +: SI16_W];
  assign si20 = inst_i[SI20_LSB +: SI20_W];
  // High part of offs26 sits in the low bits
  assign si26 = {inst_i[0 +: SI26_W-SI16_W], si16};

  assign sext12 = {{(WORD_W-SI12_W){si12[SI12_W-1]}}, si12};
  assign zext12 = {{(WORD_W-SI12_W){1'b0}}, si12};
  assign offs16 = {{(WORD_W-SI16_W-2){si16[SI16_W-1]}}, si16, 2'b00};
  assign offs26 = {{(WORD_W-SI26_W-2){si26[SI26_W-1]}}, si26, 2'b00};

  always_comb
  begin
    casez (prefix)
      {OPC6_JIRL, 11'b?}:        alu_op_o = OP_JIRL;
      {OPC6_B, 11'b?}:           alu_op_o = OP_B;
      {OPC6_BL, 11'b?}:          alu_op_o = OP_BL;
      {OPC6_BEQ, 11'b?}:         alu_op_o = OP_BEQ;
      {OPC6_BNE, 11'b?}:         alu_op_o = OP_BNE;
      {OPC6_BLT, 11'b?}:         alu_op_o = OP_BLT;
      {OPC6_BGE, 11'b?}:         alu_op_o = OP_BGE;
      {OPC6_BLTU, 11'b?}:        alu_op_o = OP_BLTU;
      {OPC6_BGEU, 11'b?}:        alu_op_o = OP_BGEU;
      {OPC7_LU12I_W, 10'b?}:     alu_op_o = OP_LUI;
      {OPC7_PCADDU12I, 10'b?}:   alu_op_o = OP_PCADD;
      {OPC10_SLTI, 7'b?}:        alu_op_o = OP_SLT;
      {OPC10_SLTUI, 7'b?}:       alu_op_o = OP_SLTU;
      {OPC10_ADDI_W, 7'b?}:      alu_op_o = OP_ADD;
      {OPC10_ANDI, 7'b?}:        alu_op_o = OP_AND;
      {OPC10_ORI, 7'b?}:         alu_op_o = OP_OR;
      {OPC10_XORI, 7'b?}:        alu_op_o = OP_XOR;
      {OPC10_LD_B, 7'b?}:        alu_op_o = OP_LD_B;
      {OPC10_LD_H, 7'b?}:        alu_op_o = OP_LD_H;
      {OPC10_LD_W, 7'b?}:        alu_op_o = OP_LD_W;
      {OPC10_ST_B, 7'b?}:        alu_op_o = OP_ST_B;
      {OPC10_ST_H, 7'b?}:        alu_op_o = OP_ST_H;
      {OPC10_ST_W, 7'b?}:        alu_op_o = OP_ST_W;
      {OPC10_LD_BU, 7'b?}:       alu_op_o = OP_LD_BU;
      {OPC10_LD_HU, 7'b?}:       alu_op_o = OP_LD_HU;
      OPC17_ADD_W:               alu_op_o = OP_ADD;
      OPC17_SUB_W:               alu_op_o = OP_SUB;
      OPC17_SLT:                 alu_op_o = OP_SLT;
      OPC17_SLTU:                alu_op_o = OP_SLTU;
      OPC17_NOR:                 alu_op_o = OP_NOR;
      OPC17_AND:                 alu_op_o = OP_AND;
      OPC17_OR:                  alu_op_o = OP_OR;
      OPC17_XOR:                 alu_op_o = OP_XOR;
      OPC17_SLL_W, OPC17_SLLI_W: alu_op_o = OP_SLL;
      OPC17_SRL_W, OPC17_SRLI_W: alu_op_o = OP_SRL;
      OPC17_SRA_W, OPC17_SRAI_W: alu_op_o = OP_SRA;
      OPC17_BREAK:               alu_op_o = OP_BREAK;
      OPC17_SYSCALL:             alu_op_o = OP_SYSCALL;
      default:                   alu_op_o = OP_NOP;
    endcase
  end

  assign raddr1_o = rj;

  always_comb
  begin
    alu_sel_o = SEL_NOP;
    re1_o     = 1'b0;
    re2_o     = 1'b0;
    raddr2_o  = rk;
    wreg_o    = 1'b0;
    waddr_o   = rd;
    imm_o     = '0;
    use_imm_o = 1'b0;
    case (alu_op_o)
      OP_ADD, OP_SUB, OP_SLT, OP_SLTU:
      begin
        alu_sel_o = SEL_ARITH;
        re1_o     = 1'b1;
        re2_o     = reg_form;
        wreg_o    = 1'b1;
        imm_o     = sext12;
        use_imm_o = ~reg_form;
      end
      OP_AND, OP_OR, OP_NOR, OP_XOR:
      begin
        alu_sel_o = SEL_LOGIC;
        re1_o     = 1'b1;
        re2_o     = reg_form;
        wreg_o    = 1'b1;
        imm_o     = zext12;
        use_imm_o = ~reg_form;
      end
      OP_SLL, OP_SRL, OP_SRA:
      begin
        alu_sel_o = SEL_SHIFT;
        re1_o     = 1'b1;
        re2_o     = reg_form;
        wreg_o    = 1'b1;
        imm_o     = {{(WORD_W-UI5_W){1'b0}}, ui5};
        use_imm_o = ~reg_form;
      end
      OP_LUI, OP_PCADD:
      begin
        alu_sel_o = SEL_MOVE;
        wreg_o    = 1'b1;
        imm_o     = {si20, 12'h000};
        use_imm_o = 1'b1;
      end
      OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU:
      begin
        alu_sel_o = SEL_LOAD_STORE;
        re1_o     = 1'b1;
        wreg_o    = 1'b1;
        imm_o     = sext12;
        use_imm_o = 1'b1;
      end
      OP_ST_B, OP_ST_H, OP_ST_W:
      begin
        // Store data comes from rd
        alu_sel_o = SEL_LOAD_STORE;
        re1_o     = 1'b1;
        re2_o     = 1'b1;
        raddr2_o  = rd;
        imm_o     = sext12;
      end
      OP_B, OP_BL:
      begin
        alu_sel_o = SEL_JUMP;
        wreg_o    = (alu_op_o == OP_BL);
        waddr_o   = LINK_REG;
        imm_o     = offs26;
      end
      OP_JIRL:
      begin
        alu_sel_o = SEL_JUMP;
        re1_o     = 1'b1;
        wreg_o    = 1'b1;
        imm_o     = offs16;
      end
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
      begin
        alu_sel_o = SEL_JUMP;
        re1_o     = 1'b1;
        re2_o     = 1'b1;
        raddr2_o  = rd;
        imm_o     = offs16;
      end
      default:
      begin
      end
    endcase
  end

  // Nothing matched means ine
  assign excp_code_o = '{sys: (alu_op_o == OP_SYSCALL),
                         brk: (alu_op_o == OP_BREAK),
                         ine: (alu_op_o == OP_NOP)};

endmodule

//--- hdl/loong_isa_pkg.sv
package loong_isa_pkg;

  // Register fields
  localparam int REG_W  = 5;
  localparam int RD_LSB = 0;
  localparam int RJ_LSB = 5;
  localparam int RK_LSB = 10;

  // Immediate fields
  localparam int IMM_LSB  = 10;
  localparam int SI20_LSB = 5;
  localparam int SI12_W   = 12;
  localparam int UI5_W    = 5;
  localparam int SI16_W   = 16;
  localparam int SI26_W   = 26;
  localparam int SI20_W   = 20;

  // 6-bit prefixes, jumps and branches
  localparam logic [5:0] OPC6_JIRL = 6'b010011;
  localparam logic [5:0] OPC6_B    = 6'b010100;
  localparam logic [5:0] OPC6_BL   = 6'b010101;
  localparam logic [5:0] OPC6_BEQ  = 6'b010110;
  localparam logic [5:0] OPC6_BNE  = 6'b010111;
  localparam logic [5:0] OPC6_BLT  = 6'b011000;
  localparam logic [5:0] OPC6_BGE  = 6'b011001;
  localparam logic [5:0] OPC6_BLTU = 6'b011010;
  localparam logic [5:0] OPC6_BGEU = 6'b011011;

  // 7-bit prefixes
  localparam logic [6:0] OPC7_LU12I_W   = 7'b0001010;
  localparam logic [6:0] OPC7_PCADDU12I = 7'b0001110;

  // 10-bit prefixes, 2RI12 forms
  localparam logic [9:0] OPC10_SLTI   = 10'b0000001000;
  localparam logic [9:0] OPC10_SLTUI  = 10'b0000001001;
  localparam logic [9:0] OPC10_ADDI_W = 10'b0000001010;
  localparam logic [9:0] OPC10_ANDI   = 10'b0000001101;
  localparam logic [9:0] OPC10_ORI    = 10'b0000001110;
  localparam logic [9:0] OPC10_XORI   = 10'b0000001111;
  localparam logic [9:0] OPC10_LD_B   = 10'b0010100000;
  localparam logic [9:0] OPC10_LD_H   = 10'b0010100001;
  localparam logic [9:0] OPC10_LD_W   = 10'b0010100010;
  localparam logic [9:0] OPC10_ST_B   = 10'b0010100100;
  localparam logic [9:0] OPC10_ST_H   = 10'b0010100101;
  localparam logic [9:0] OPC10_ST_W   = 10'b0010100110;
  localparam logic [9:0] OPC10_LD_BU  = 10'b0010101000;
  localparam logic [9:0] OPC10_LD_HU  = 10'b0010101001;

  // 17-bit prefixes, 3R forms, shift immediates and traps
  localparam logic [16:0] OPC17_ADD_W   = 17'b00000000000100000;
  localparam logic [16:0] OPC17_SUB_W   = 17'b00000000000100010;
  localparam logic [16:0] OPC17_SLT     = 17'b00000000000100100;
  localparam logic [16:0] OPC17_SLTU    = 17'b00000000000100101;
  localparam logic [16:0] OPC17_NOR     = 17'b00000000000101000;
  localparam logic [16:0] OPC17_AND     = 17'b00000000000101001;
  localparam logic [16:0] OPC17_OR      = 17'b00000000000101010;
  localparam logic [16:0] OPC17_XOR     = 17'b00000000000101011;
  localparam logic [16:0] OPC17_SLL_W   = 17'b00000000000101110;
  localparam logic [16:0] OPC17_SRL_W   = 17'b00000000000101111;
  localparam logic [16:0] OPC17_SRA_W   = 17'b00000000000110000;
  localparam logic [16:0] OPC17_BREAK   = 17'b00000000001010100;
  localparam logic [16:0] OPC17_SYSCALL = 17'b00000000001010110;
  localparam logic [16:0] OPC17_SLLI_W  = 17'b00000000010000001;
  localparam logic [16:0] OPC17_SRLI_W  = 17'b00000000010001001;
  localparam logic [16:0] OPC17_SRAI_W  = 17'b00000000010010001;

endpackage

//--- hdl/operand_forward.sv
module operand_forward (
  input  logic              re_i,
  input  id_pkg::reg_addr_t raddr_i,
  input  id_pkg::word_t     rf_data_i,
  input  logic              ex_wreg_i,
  input  id_pkg::reg_addr_t ex_waddr_i,
  input  id_pkg::word_t     ex_wdata_i,
  input  id_pkg::alu_op_e   ex_alu_op_i,
  input  logic              mem_wreg_i,
  input  id_pkg::reg_addr_t mem_waddr_i,
  input  id_pkg::word_t     mem_wdata_i,
  input  logic              use_imm_i,
  input  id_pkg::word_t     imm_i,
  output id_pkg::word_t     operand_o,
  output logic              load_hazard_o
);

  import id_pkg::*;

  logic ex_load;
  logic ex_hit;
  logic mem_hit;

  assign ex_load = ex_alu_op_i inside {OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU};
  assign ex_hit  = ex_wreg_i && (ex_waddr_i == raddr_i);
  assign mem_hit = mem_wreg_i && (mem_waddr_i == raddr_i);

  // EX wins over MEM, MEM over the register file
  always_comb
  begin
    if (!re_i)
      operand_o = use_imm_i ? imm_i : '0;
    else if (raddr_i == '0)
      operand_o = '0;
    else if (ex_hit)
      operand_o = ex_wdata_i;
    else if (mem_hit)
      operand_o = mem_wdata_i;
    else
      operand_o = rf_data_i;
  end

  // Load data is not ready until MEM
  assign load_hazard_o = re_i && (raddr_i != '0) && ex_load && ex_hit;

endmodule

//--- sources.f
hdl/id_pkg.sv
hdl/loong_isa_pkg.sv
hdl/inst_decoder.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/id_ex_register.sv
hdl/id_stage_top.sv
testbench/tb_id_stage.sv

//--- testbench/tb_id_stage.sv
module tb_id_stage;

  import id_pkg::*;
  import loong_isa_pkg::*;

  localparam int unsigned SEED = 32'hb7b2;
  // Tests take about 40 cycles, limit leaves a wide margin
  localparam int MAX_CYCLES = 400;

  logic       clk;
  logic       rst_n_i;
  logic       if_valid_i;
  word_t      pc_i;
  word_t      inst_i;
  logic       rf_re1_o;
  reg_addr_t  rf_addr1_o;
  logic       rf_re2_o;
  reg_addr_t  rf_addr2_o;
  word_t      rf_data1_i;
  word_t      rf_data2_i;
  logic       ex_wreg_i;
  reg_addr_t  ex_waddr_i;
  word_t      ex_wdata_i;
  alu_op_e    ex_alu_op_i;
  logic       mem_wreg_i;
  reg_addr_t  mem_waddr_i;
  word_t      mem_wdata_i;
  logic       stall_o;
  logic       ex_valid_o;
  word_t      ex_pc_o;
  alu_op_e    ex_alu_op_o;
  alu_sel_e   ex_alu_sel_o;
  word_t      ex_src1_o;
  word_t      ex_src2_o;
  word_t      ex_offset_o;
  logic       ex_wreg_o;
  reg_addr_t  ex_waddr_o;
  word_t      ex_link_o;
  logic       br_taken_o;
  word_t      br_target_o;
  logic       excp_o;
  excp_code_t excp_code_o;

  word_t       regs [32];
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;

  id_stage_top u_id_stage_top (.*);

  // Register file model answers in the same cycle
  assign rf_data1_i = regs[rf_addr1_o];
  assign rf_data2_i = regs[rf_addr2_o];

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic word_t r3_inst(logic [16:0] opc, reg_addr_t rk, reg_addr_t rj,
                                    reg_addr_t rd);
    return {opc, rk, rj, rd};
  endfunction

  function automatic word_t ri12_inst(logic [9:0] opc, logic [11:0] si12, reg_addr_t rj,
                                      reg_addr_t rd);
    return {opc, si12, rj, rd};
  endfunction

  function automatic word_t ri20_inst(logic [6:0] opc, logic [19:0] si20, reg_addr_t rd);
    return {opc, si20, rd};
  endfunction

  function automatic word_t ri16_inst(logic [5:0] opc, logic [15:0] offs, reg_addr_t rj,
                                      reg_addr_t rd);
    return {opc, offs, rj, rd};
  endfunction

  // Upper ten offset bits go in the low field
  function automatic word_t i26_inst(logic [5:0] opc, logic [25:0] offs);
    return {opc, offs[15:0], offs[25:16]};
  endfunction

  function automatic excp_code_t excp_bits(logic sys, logic brk, logic ine);
    excp_code_t code;
    code.sys = sys;
    code.brk = brk;
    code.ine = ine;
    return code;
  endfunction

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_op(input string what, input alu_op_e got, input alu_op_e exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_sel(input string what, input alu_sel_e got, input alu_sel_e exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_excp(input string what, input excp_code_t got,
                            input excp_code_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Called 1 unit after an edge, returns 1 unit after the capture edge
  task automatic issue_inst(input word_t pc, input word_t inst);
    pc_i       = pc;
    inst_i     = inst;
    if_valid_i = 1'b1;
    #1;
    check_bit("stall on issue", stall_o, 1'b0);
    @(posedge clk);
    #1;
    if_valid_i = 1'b0;
  endtask

  task automatic clear_bypass();
    ex_wreg_i   = 1'b0;
    ex_waddr_i  = '0;
    ex_wdata_i  = '0;
    ex_alu_op_i = OP_NOP;
    mem_wreg_i  = 1'b0;
    mem_waddr_i = '0;
    mem_wdata_i = '0;
  endtask

  task automatic check_bubble(input string what);
    check_bit({what, " valid"}, ex_valid_o, 1'b0);
    check_bit({what, " wreg"}, ex_wreg_o, 1'b0);
    check_bit({what, " taken"}, br_taken_o, 1'b0);
    check_bit({what, " excp"}, excp_o, 1'b0);
    check_op({what, " op"}, ex_alu_op_o, OP_NOP);
  endtask

  task automatic test_reset_state();
    @(posedge clk);
    #1;
    check_bubble("idle after reset");
  endtask

  task automatic test_alu_decode();
    issue_inst(32'h1c00_0000, r3_inst(OPC17_ADD_W, 5'd6, 5'd5, 5'd3));
    check_bit("add valid", ex_valid_o, 1'b1);
    check_op("add op", ex_alu_op_o, OP_ADD);
    check_sel("add sel", ex_alu_sel_o, SEL_ARITH);
    check_bit("add reads rj", rf_re1_o, 1'b1);
    check_bit("add reads rk", rf_re2_o, 1'b1);
    check_word("add src1", ex_src1_o, regs[5]);
    check_word("add src2", ex_src2_o, regs[6]);
    check_word("add waddr", {27'd0, ex_waddr_o}, 32'd3);
    check_bit("add wreg", ex_wreg_o, 1'b1);
    issue_inst(32'h1c00_0004, r3_inst(OPC17_SUB_W, 5'd14, 5'd13, 5'd12));
    check_op("sub op", ex_alu_op_o, OP_SUB);
    check_word("sub src1", ex_src1_o, regs[13]);
    check_word("sub src2", ex_src2_o, regs[14]);
    check_word("sub waddr", {27'd0, ex_waddr_o}, 32'd12);
    issue_inst(32'h1c00_0008, ri12_inst(OPC10_ADDI_W, 12'hffb, 5'd7, 5'd4));
    check_op("addi op", ex_alu_op_o, OP_ADD);
    check_bit("addi reads rk", rf_re2_o, 1'b0);
    check_word("addi src1", ex_src1_o, regs[7]);
    check_word("addi imm", ex_src2_o, 32'hffff_fffb);
    issue_inst(32'h1c00_000c, ri12_inst(OPC10_ORI, 12'h8a5, 5'd9, 5'd8));
    check_op("ori op", ex_alu_op_o, OP_OR);
    check_sel("ori sel", ex_alu_sel_o, SEL_LOGIC);
    check_word("ori imm", ex_src2_o, 32'h0000_08a5);
    issue_inst(32'h1c00_0010, r3_inst(OPC17_SLLI_W, 5'd13, 5'd11, 5'd10));
    check_op("slli op", ex_alu_op_o, OP_SLL);
    check_sel("slli sel", ex_alu_sel_o, SEL_SHIFT);
    check_word("slli src1", ex_src1_o, regs[11]);
    check_word("slli imm", ex_src2_o, 32'd13);
    issue_inst(32'h1c00_0014, ri20_inst(OPC7_LU12I_W, 20'h81234, 5'd15));
    check_op("lu12i op", ex_alu_op_o, OP_LUI);
    check_sel("lu12i sel", ex_alu_sel_o, SEL_MOVE);
    check_bit("lu12i reads rj", rf_re1_o, 1'b0);
    check_word("lu12i imm", ex_src2_o, 32'h8123_4000);
    check_word("lu12i waddr", {27'd0, ex_waddr_o}, 32'd15);
    issue_inst(32'h1c00_0018, r3_inst(OPC17_ADD_W, 5'd0, 5'd0, 5'd2));
    check_word("r0 src1", ex_src1_o, 32'h0);
    check_word("r0 src2", ex_src2_o, 32'h0);
  endtask

  task automatic test_forwarding();
    ex_wreg_i   = 1'b1;
    ex_waddr_i  = 5'd7;
    ex_wdata_i  = 32'he1e1_0001;
    ex_alu_op_i = OP_ADD;
    mem_wreg_i  = 1'b1;
    mem_waddr_i = 5'd7;
    mem_wdata_i = 32'ha5a5_0002;
    issue_inst(32'h1c00_0100, r3_inst(OPC17_ADD_W, 5'd8, 5'd7, 5'd3));
    check_word("EX over MEM", ex_src1_o, 32'he1e1_0001);
    check_word("unforwarded src2", ex_src2_o, regs[8]);
    ex_wreg_i = 1'b0;
    issue_inst(32'h1c00_0104, r3_inst(OPC17_ADD_W, 5'd8, 5'd7, 5'd3));
    check_word("MEM over regfile", ex_src1_o, 32'ha5a5_0002);
    clear_bypass();
  endtask

  task automatic test_branches();
    regs[20] = 32'hffff_fff0;
    regs[21] = 32'h0000_0010;
    regs[22] = 32'h0000_0010;
    regs[18] = 32'h0000_2000;
    regs[24] = 32'h0000_3000;
    issue_inst(32'h1000_0000, ri16_inst(OPC6_BEQ, 16'h0010, 5'd21, 5'd22));
    check_bit("beq equal taken", br_taken_o, 1'b1);
    check_sel("beq sel", ex_alu_sel_o, SEL_JUMP);
    check_bit("beq reads rd", rf_re2_o, 1'b1);
    check_word("beq rd address", {27'd0, rf_addr2_o}, 32'd22);
    check_word("beq target", br_target_o, 32'h1000_0040);
    issue_inst(32'h1000_0000, ri16_inst(OPC6_BNE, 16'h0010, 5'd21, 5'd22));
    check_bit("bne equal taken", br_taken_o, 1'b0);
    issue_inst(32'h1000_0000, ri16_inst(OPC6_BEQ, 16'h0010, 5'd20, 5'd21));
    check_bit("beq unequal taken", br_taken_o, 1'b0);
    issue_inst(32'h1000_0000, ri16_inst(OPC6_BNE, 16'h0010, 5'd20, 5'd21));
    check_bit("bne unequal taken", br_taken_o, 1'b1);
    issue_inst(32'h1000_0000, ri16_inst(OPC6_BLT, 16'h0010, 5'd20, 5'd21));
    check_bit("blt negative taken", br_taken_o, 1'b1);
    issue_inst(32'h1000_0000, ri16_inst(OPC6_BLTU, 16'h0010, 5'd20, 5'd21));
    check_bit("bltu negative taken", br_taken_o, 1'b0);
    issue_inst(32'h1000_0100, i26_inst(OPC6_B, 26'h3ff_fff8));
    check_bit("b taken", br_taken_o, 1'b1);
    check_word("b target", br_target_o, 32'h1000_00e0);
    check_bit("b wreg", ex_wreg_o, 1'b0);
    issue_inst(32'h1000_0200, i26_inst(OPC6_BL, 26'h000_0100));
    check_word("bl target", br_target_o, 32'h1000_0600);
    check_bit("bl wreg", ex_wreg_o, 1'b1);
    check_word("bl waddr", {27'd0, ex_waddr_o}, 32'd1);
    check_word("bl link", ex_link_o, 32'h1000_0204);
    issue_inst(32'h1000_0300, ri16_inst(OPC6_JIRL, 16'hffff, 5'd18, 5'd17));
    check_bit("jirl taken", br_taken_o, 1'b1);
    check_word("jirl target", br_target_o, 32'h0000_1ffc);
    check_word("jirl link", ex_link_o, 32'h1000_0304);
    check_word("jirl waddr", {27'd0, ex_waddr_o}, 32'd17);
    issue_inst(32'h1000_0400, ri12_inst(OPC10_LD_W, 12'hf00, 5'd24, 5'd23));
    check_op("ld.w op", ex_alu_op_o, OP_LD_W);
    check_sel("ld.w sel", ex_alu_sel_o, SEL_LOAD_STORE);
    check_word("ld.w base", ex_src1_o, 32'h0000_3000);
    check_word("ld.w offset", ex_offset_o, 32'hffff_ff00);
    check_word("ld.w address", ex_src1_o + ex_offset_o, 32'h0000_2f00);
  endtask

  task automatic test_load_use();
    ex_wreg_i   = 1'b1;
    ex_waddr_i  = 5'd9;
    ex_wdata_i  = 32'hdead_0009;
    ex_alu_op_i = OP_LD_W;
    pc_i        = 32'h1c00_0200;
    inst_i      = r3_inst(OPC17_ADD_W, 5'd10, 5'd9, 5'd4);
    if_valid_i  = 1'b1;
    #1;
    check_bit("load-use stall", stall_o, 1'b1);
    @(posedge clk);
    #1;
    check_bubble("stall bubble");
    // Load moves on to MEM
    clear_bypass();
    mem_wreg_i  = 1'b1;
    mem_waddr_i = 5'd9;
    mem_wdata_i = 32'h1234_5678;
    #1;
    check_bit("stall released", stall_o, 1'b0);
    @(posedge clk);
    #1;
    if_valid_i = 1'b0;
    check_bit("held inst valid", ex_valid_o, 1'b1);
    check_word("held inst pc", ex_pc_o, 32'h1c00_0200);
    check_word("load data from MEM", ex_src1_o, 32'h1234_5678);
    check_word("held inst src2", ex_src2_o, regs[10]);
    clear_bypass();
    @(posedge clk);
    #1;
    check_bubble("after single issue");
  endtask

  task automatic test_exceptions();
    issue_inst(32'h1c00_0300, 32'hffff_ffff);
    check_bit("ine valid", ex_valid_o, 1'b1);
    check_bit("ine excp", excp_o, 1'b1);
    check_excp("ine code", excp_code_o, excp_bits(1'b0, 1'b0, 1'b1));
    issue_inst(32'h1c00_0304, r3_inst(OPC17_SYSCALL, 5'd0, 5'd0, 5'd0));
    check_bit("syscall excp", excp_o, 1'b1);
    check_excp("syscall code", excp_code_o, excp_bits(1'b1, 1'b0, 1'b0));
    issue_inst(32'h1c00_0308, r3_inst(OPC17_BREAK, 5'd0, 5'd0, 5'd0));
    check_bit("break excp", excp_o, 1'b1);
    check_excp("break code", excp_code_o, excp_bits(1'b0, 1'b1, 1'b0));
  endtask

  initial
  begin
    regs[0] = $urandom(SEED);
    for (int i = 1; i < 32; i++)
      regs[i] = $urandom;
    // Nonzero so that r0 reads prove the DUT ignores the file
    regs[0] = regs[0] | 32'h1;
    rst_n_i    = 1'b0;
    if_valid_i = 1'b0;
    pc_i       = '0;
    inst_i     = '0;
    clear_bypass();
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    test_reset_state();
    test_alu_decode();
    test_forwarding();
    test_branches();
    test_load_use();
    test_exceptions();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
